/* led_matrix_ctrl.f */
verilog/matrix_pkg.sv
verilog/cmd_fsm.sv
verilog/blank_counter.sv
verilog/pixel_writer.sv
verilog/display_settings.sv
verilog/led_matrix_ctrl.sv
testbench/tb_clock.sv
testbench/led_matrix_ctrl_chk.sv
testbench/led_matrix_ctrl_tb.sv

/* testbench/led_matrix_ctrl_chk.sv */
// concurrent checks on handshake and ram write port
// bound into the controller top level

`timescale 1ns/1ps

module led_matrix_ctrl_chk (
    input logic                             clk_in,
    input logic                             reset,
    input logic                             ready_for_data,
    input logic                             busy,
    input logic [matrix_pkg::ADDR_BITS-1:0] ram_address,
    input logic                             ram_write_enable
);
    import matrix_pkg::*;

    // writes only happen while a command is in flight
    write_needs_busy: assert property (
        @(posedge clk_in) disable iff (reset)
        ram_write_enable |-> busy
    ) else $error("ram write enable high while controller is idle");

    // back-pressure only during a blank, busy also spans the cycle after it
    ready_low_needs_busy: assert property (
        @(posedge clk_in) disable iff (reset)
        (!ready_for_data || !$past(ready_for_data)) |-> busy
    ) else $error("controller idle during or just after ready_for_data low");

    // blank sweep writes one address after another
    blank_addr_ascending: assert property (
        @(posedge clk_in) disable iff (reset)
        (ram_write_enable && $past(ram_write_enable) && !ready_for_data)
            |-> (ram_address == ADDR_BITS'($past(ram_address) + 1'b1))
    ) else $error("blank write address did not advance by one");

endmodule

bind led_matrix_ctrl led_matrix_ctrl_chk chk (
    .clk_in           (clk_in),
    .reset            (reset),
    .ready_for_data   (ready_for_data),
    .busy             (busy),
    .ram_address      (ram_address),
    .ram_write_enable (ram_write_enable)
);

/* testbench/led_matrix_ctrl_tb.sv */
// testbench for the led matrix controller
// command table, byte driver, ram model, checks and timeout

`timescale 1ns/1ps

module led_matrix_ctrl_tb;
    import matrix_pkg::*;

    localparam int RESET_CYCLES = 8;
    localparam int MAX_BYTES = 8;
    localparam int MAX_TESTS = 12;
    localparam int MAX_GAP = 6;
    localparam int WR_BITS = ADDR_BITS + DATA_BITS;

    logic                         clk_in;
    logic                         reset;
    logic [DATA_BITS-1:0]         data_rx;
    logic                         data_ready_n;
    logic                         ready_for_data;
    logic                         busy;
    logic [RGB_CHANNELS-1:0]      rgb_enable;
    logic [BRIGHTNESS_LEVELS-1:0] brightness_enable;
    logic [ADDR_BITS-1:0]         ram_address;
    logic [DATA_BITS-1:0]         ram_data;
    logic                         ram_write_enable;

    // command table
    string                        test_name [MAX_TESTS];
    logic [DATA_BITS-1:0]         seq [MAX_TESTS][MAX_BYTES];
    int                           seq_len [MAX_TESTS];
    logic [RGB_CHANNELS-1:0]      exp_rgb [MAX_TESTS];
    logic [BRIGHTNESS_LEVELS-1:0] exp_bright [MAX_TESTS];
    logic [WR_BITS-1:0]           exp_wr [MAX_TESTS][2];
    int                           exp_count [MAX_TESTS];
    bit                           exp_blank [MAX_TESTS];
    int                           num_tests = 0;
    int                           total_bytes = 0;

    // ram model and write log
    logic [DATA_BITS-1:0]         mem [RAM_DEPTH];
    logic [DATA_BITS-1:0]         exp_mem [RAM_DEPTH];
    logic [WR_BITS-1:0]           wlog [$];
    logic [WR_BITS-1:0]           exp_q [$];

    int                           cycle_count = 0;
    int                           cycle_limit = 0;

    tb_clock #(.PERIOD_NS(100.0)) u_clock (.clk_in(clk_in));

    led_matrix_ctrl dut (
        .clk_in            (clk_in),
        .reset             (reset),
        .data_rx           (data_rx),
        .data_ready_n      (data_ready_n),
        .ready_for_data    (ready_for_data),
        .busy              (busy),
        .rgb_enable        (rgb_enable),
        .brightness_enable (brightness_enable),
        .ram_address       (ram_address),
        .ram_data          (ram_data),
        .ram_write_enable  (ram_write_enable)
    );

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1);
    endtask

    // row, column, byte select, then the data byte
    function automatic logic [WR_BITS-1:0] pix_wr(input int row, input int col,
                                                  input bit sel, input logic [7:0] data);
        return {ROW_BITS'(row), COL_BITS'(col), sel, data};
    endfunction

    // bytes are packed first byte in the top lane
    task automatic add_entry(input string name, input logic [8*MAX_BYTES-1:0] bytes,
                             input int len, input logic [2:0] rgb, input logic [5:0] bright,
                             input int nwr, input logic [WR_BITS-1:0] w0,
                             input logic [WR_BITS-1:0] w1, input bit blank);
        test_name[num_tests] = name;
        for (int i = 0; i < MAX_BYTES; i++) begin
            seq[num_tests][i] = bytes[8*(MAX_BYTES-i)-1 -: 8];
        end
        seq_len[num_tests] = len;
        exp_rgb[num_tests] = rgb;
        exp_bright[num_tests] = bright;
        exp_count[num_tests] = nwr;
        exp_wr[num_tests][0] = w0;
        exp_wr[num_tests][1] = w1;
        exp_blank[num_tests] = blank;
        total_bytes += len;
        num_tests++;
    endtask

    task automatic send_byte(input logic [DATA_BITS-1:0] b);
        int  gap;
        bit  accepted;
        gap = $urandom_range(0, MAX_GAP);
        repeat (gap) @(posedge clk_in);
        @(negedge clk_in);
        while (!ready_for_data) @(negedge clk_in);
        @(posedge clk_in);
        data_rx <= b;
        data_ready_n <= 1'b0;
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge clk_in);
            accepted = ready_for_data;
            @(posedge clk_in);
        end
        data_ready_n <= 1'b1;
    endtask

    // settings land one cycle after the strobe
    task automatic wait_idle();
        repeat (2) @(negedge clk_in);
        while (busy) @(negedge clk_in);
    endtask

    always @(negedge clk_in) begin
        if (!reset && ram_write_enable) begin
            wlog.push_back({ram_address, ram_data});
            mem[ram_address] = ram_data;
        end
    end

    always @(posedge clk_in) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            fail_run($sformatf("timeout: run did not finish within %0d cycles", cycle_limit));
        end
    end

    initial begin
        reset = 1'b1;
        data_rx = '0;
        data_ready_n = 1'b1;
        void'($urandom(32'hb6f0_fcdc));
        for (int a = 0; a < RAM_DEPTH; a++) begin
            mem[a] = 8'(a ^ (a >> 4) ^ (a >> 8));
            exp_mem[a] = mem[a];
        end

        add_entry("colour", {"r", 8'h7e, "g", "B", "x", "G", 16'h0}, 6,
                  3'b110, 6'b111111, 0, '0, '0, 1'b0);
        add_entry("bright_digits", {"0", "2", "5", 40'h0}, 3,
                  3'b110, 6'b010010, 0, '0, '0, 1'b0);
        add_entry("bright_all", {"9", 56'h0}, 1, 3'b110, 6'b111111, 0, '0, '0, 1'b0);
        add_entry("bright_load", {"T", 8'hd5, 48'h0}, 2,
                  3'b110, 6'b010101, 0, '0, '0, 1'b0);
        // argument byte is a letter but must not act as a command
        add_entry("load_then_toggle", {"T", "R", "1", "6", 32'h0}, 4,
                  3'b110, 6'b110011, 0, '0, '0, 1'b0);
        add_entry("pixel", {"P", 8'h03, 8'h0a, 8'ha5, 8'h3c, 24'h0}, 5,
                  3'b110, 6'b110011, 2, pix_wr(3, 10, 1, 8'ha5), pix_wr(3, 10, 0, 8'h3c), 1'b0);
        add_entry("pixel_high_bits", {"P", 8'hff, 8'hc5, 8'h12, 8'h34, 24'h0}, 5,
                  3'b110, 6'b110011, 2, pix_wr(31, 5, 1, 8'h12), pix_wr(31, 5, 0, 8'h34), 1'b0);
        add_entry("blank", {"P", 8'h01, 8'h02, 8'h77, 8'h88, "Z", "b", 8'h0}, 7,
                  3'b010, 6'b110011, 2, pix_wr(1, 2, 1, 8'h77), pix_wr(1, 2, 0, 8'h88), 1'b1);
        add_entry("after_blank", {"P", 8'h1f, 8'h3f, 8'hee, 8'hdd, "B", "R", 8'h0}, 7,
                  3'b111, 6'b110011, 2, pix_wr(31, 63, 1, 8'hee), pix_wr(31, 63, 0, 8'hdd), 1'b0);

        cycle_limit = RESET_CYCLES + 2 * total_bytes * MAX_GAP + 2 * 4100;

        repeat (RESET_CYCLES) @(posedge clk_in);
        reset <= 1'b0;
        @(negedge clk_in);
        assert (rgb_enable == 3'b111)
            else fail_run($sformatf("error: reset rgb_enable expected %b actual %b",
                                    3'b111, rgb_enable));
        assert (brightness_enable == 6'b111111)
            else fail_run($sformatf("error: reset brightness_enable expected %b actual %b",
                                    6'b111111, brightness_enable));
        assert (!ram_write_enable && !busy && ready_for_data)
            else fail_run($sformatf("error: reset we/busy/ready expected 001 actual %b%b%b",
                                    ram_write_enable, busy, ready_for_data));
        assert (wlog.size() == 0)
            else fail_run($sformatf("error: reset write count expected 0 actual %0d",
                                    wlog.size()));

        for (int t = 0; t < num_tests; t++) begin
            wlog.delete();
            exp_q.delete();
            for (int k = 0; k < exp_count[t]; k++) begin
                exp_q.push_back(exp_wr[t][k]);
            end
            if (exp_blank[t]) begin
                for (int a = 0; a < RAM_DEPTH; a++) begin
                    exp_q.push_back({ADDR_BITS'(a), 8'h00});
                end
            end
            for (int b = 0; b < seq_len[t]; b++) begin
                send_byte(seq[t][b]);
            end
            wait_idle();

            assert (rgb_enable == exp_rgb[t])
                else fail_run($sformatf("error: %s rgb_enable expected %b actual %b",
                                        test_name[t], exp_rgb[t], rgb_enable));
            assert (brightness_enable == exp_bright[t])
                else fail_run($sformatf("error: %s brightness_enable expected %b actual %b",
                                        test_name[t], exp_bright[t], brightness_enable));
            assert (wlog.size() == exp_q.size())
                else fail_run($sformatf("error: %s write count expected %0d actual %0d",
                                        test_name[t], exp_q.size(), wlog.size()));
            for (int i = 0; i < exp_q.size(); i++) begin
                assert (wlog[i] == exp_q[i])
                    else fail_run($sformatf("error: %s write %0d expected %h actual %h",
                                            test_name[t], i, exp_q[i], wlog[i]));
                exp_mem[exp_q[i][WR_BITS-1 -: ADDR_BITS]] = exp_q[i][DATA_BITS-1:0];
            end
            // whole frame against the expected image
            for (int a = 0; a < RAM_DEPTH; a++) begin
                assert (mem[a] == exp_mem[a])
                    else fail_run($sformatf("error: %s ram[%0d] expected %h actual %h",
                                            test_name[t], a, exp_mem[a], mem[a]));
            end
        end

        $display("Verification passed");
        $finish;
    end

endmodule

/* testbench/tb_clock.sv */
// free running clock for the testbench

`timescale 1ns/1ps

module tb_clock #(
    parameter real PERIOD_NS = 100.0
) (
    output logic clk_in
);

    initial begin
        clk_in = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0) clk_in = ~clk_in;
        end
    end

endmodule

/* verilog/blank_counter.sv */
// address sweep over the whole frame ram for a blank

`timescale 1ns/1ps

module blank_counter (
    input  logic                             clk_in,
    input  logic                             reset,
    input  logic                             blank_start,
    output logic                             blank_active,
    output logic [matrix_pkg::ADDR_BITS-1:0] blank_addr,
    output logic                             blank_last
);
    import matrix_pkg::*;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            blank_active <= 1'b0;
            blank_addr <= '0;
        end else if (blank_start) begin
            blank_active <= 1'b1;
            blank_addr <= '0;
        end else if (blank_active) begin
            if (blank_last) begin
                blank_active <= 1'b0;
            end
            // wraps back to zero after the top address
            blank_addr <= blank_addr + 1'b1;
        end
    end

    assign blank_last = blank_active && (blank_addr == ADDR_BITS'(RAM_DEPTH - 1));

endmodule

/* verilog/cmd_fsm.sv */
// command state machine
// decodes received bytes, drives the settings strobe and blank start

`timescale 1ns/1ps

module cmd_fsm (
    input  logic                             clk_in,
    input  logic                             reset,
    input  logic [matrix_pkg::DATA_BITS-1:0] data_rx,
    input  logic                             data_ready_n,
    input  logic                             blank_last,
    output matrix_pkg::cmd_state_t           state,
    output logic                             byte_accept,
    output logic                             ready_for_data,
    output logic                             busy,
    output logic                             settings_strobe,
    output matrix_pkg::cmd_opcode_t          settings_op,
    output logic [matrix_pkg::DATA_BITS-1:0] settings_arg,
    output logic                             blank_start
);
    import matrix_pkg::*;

    // one extra busy cycle while the final write is on the ram port
    logic wr_tail;

    // only a blank holds off the receiver
    assign ready_for_data = (state != BLANK);
    assign byte_accept = !data_ready_n && ready_for_data;
    assign busy = (state != IDLE) || wr_tail;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state <= IDLE;
            settings_strobe <= 1'b0;
            blank_start <= 1'b0;
            wr_tail <= 1'b0;
        end else begin
            settings_strobe <= 1'b0;
            blank_start <= 1'b0;
            wr_tail <= 1'b0;
            case (state)
                IDLE: begin
                    if (byte_accept) begin
                        case (data_rx)
                            OP_RED_ON, OP_RED_OFF, OP_GREEN_ON, OP_GREEN_OFF,
                            OP_BLUE_ON, OP_BLUE_OFF, OP_BRIGHT_OFF, OP_BRIGHT_ALL,
                            OP_BRIGHT_1, OP_BRIGHT_2, OP_BRIGHT_3,
                            OP_BRIGHT_4, OP_BRIGHT_5, OP_BRIGHT_6: begin
                                settings_strobe <= 1'b1;
                            end
                            OP_BRIGHT_LOAD: state <= BRIGHT_ARG;
                            OP_BLANK: begin
                                state <= BLANK;
                                blank_start <= 1'b1;
                            end
                            OP_PIXEL: state <= PIX_ROW;
                            // unknown bytes are dropped
                            default: state <= IDLE;
                        endcase
                    end
                end
                BRIGHT_ARG: begin
                    if (byte_accept) begin
                        settings_strobe <= 1'b1;
                        state <= IDLE;
                    end
                end
                BLANK: begin
                    if (blank_last) begin
                        state <= IDLE;
                        wr_tail <= 1'b1;
                    end
                end
                PIX_ROW: if (byte_accept) state <= PIX_COL;
                PIX_COL: if (byte_accept) state <= PIX_HI;
                PIX_HI: if (byte_accept) state <= PIX_LO;
                PIX_LO: begin
                    if (byte_accept) begin
                        state <= IDLE;
                        wr_tail <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // opcode and argument for display_settings
    always_ff @(posedge clk_in) begin
        if (byte_accept) begin
            if (state == BRIGHT_ARG) begin
                settings_op <= OP_BRIGHT_LOAD;
            end else begin
                settings_op <= cmd_opcode_t'(data_rx);
            end
            settings_arg <= data_rx;
        end
    end

endmodule

/* verilog/display_settings.sv */
// colour channel and brightness plane enable registers

`timescale 1ns/1ps

module display_settings (
    input  logic                                      clk_in,
    input  logic                                      reset,
    input  logic                                      settings_strobe,
    input  matrix_pkg::cmd_opcode_t                   settings_op,
    input  logic [matrix_pkg::DATA_BITS-1:0]          settings_arg,
    output logic [matrix_pkg::RGB_CHANNELS-1:0]       rgb_enable,
    output logic [matrix_pkg::BRIGHTNESS_LEVELS-1:0]  brightness_enable
);
    import matrix_pkg::*;

    // digit k toggles plane BRIGHTNESS_LEVELS - k
    int toggle_bit;

    assign toggle_bit = BRIGHTNESS_LEVELS - 1 - (int'(settings_op) - int'(OP_BRIGHT_1));

    always_ff @(posedge clk_in) begin
        if (reset) begin
            rgb_enable <= '1;
            brightness_enable <= '1;
        end else if (settings_strobe) begin
            case (settings_op)
                OP_RED_ON:    rgb_enable[0] <= 1'b1;
                OP_RED_OFF:   rgb_enable[0] <= 1'b0;
                OP_GREEN_ON:  rgb_enable[1] <= 1'b1;
                OP_GREEN_OFF: rgb_enable[1] <= 1'b0;
                OP_BLUE_ON:   rgb_enable[2] <= 1'b1;
                OP_BLUE_OFF:  rgb_enable[2] <= 1'b0;
                OP_BRIGHT_1, OP_BRIGHT_2, OP_BRIGHT_3,
                OP_BRIGHT_4, OP_BRIGHT_5, OP_BRIGHT_6: begin
                    brightness_enable[toggle_bit] <= ~brightness_enable[toggle_bit];
                end
                OP_BRIGHT_OFF: brightness_enable <= '0;
                OP_BRIGHT_ALL: brightness_enable <= '1;
                // low bits of the argument byte become the mask
                OP_BRIGHT_LOAD: begin
                    brightness_enable <= settings_arg[BRIGHTNESS_LEVELS-1:0];
                end
                default: brightness_enable <= brightness_enable;
            endcase
        end
    end

endmodule

/* verilog/led_matrix_ctrl.sv */
// top level of the led matrix byte command controller
// fsm, blank sweep, ram write port and display enables

`timescale 1ns/1ps

module led_matrix_ctrl (
    input  logic                                      clk_in,
    input  logic                                      reset,
    input  logic [matrix_pkg::DATA_BITS-1:0]          data_rx,
    input  logic                                      data_ready_n,
    output logic                                      ready_for_data,
    output logic                                      busy,
    output logic [matrix_pkg::RGB_CHANNELS-1:0]       rgb_enable,
    output logic [matrix_pkg::BRIGHTNESS_LEVELS-1:0]  brightness_enable,
    output logic [matrix_pkg::ADDR_BITS-1:0]          ram_address,
    output logic [matrix_pkg::DATA_BITS-1:0]          ram_data,
    output logic                                      ram_write_enable
);
    import matrix_pkg::*;

    // fsm to writer
    cmd_state_t           fsm_state;
    logic                 byte_accept;

    // fsm to settings
    logic                 settings_strobe;
    cmd_opcode_t          settings_op;
    logic [DATA_BITS-1:0] settings_arg;

    // blank sweep
    logic                 blank_start;
    logic                 blank_active;
    logic [ADDR_BITS-1:0] blank_addr;
    logic                 blank_last;

    cmd_fsm u_cmd_fsm (
        .clk_in          (clk_in),
        .reset           (reset),
        .data_rx         (data_rx),
        .data_ready_n    (data_ready_n),
        .blank_last      (blank_last),
        .state           (fsm_state),
        .byte_accept     (byte_accept),
        .ready_for_data  (ready_for_data),
        .busy            (busy),
        .settings_strobe (settings_strobe),
        .settings_op     (settings_op),
        .settings_arg    (settings_arg),
        .blank_start     (blank_start)
    );

    blank_counter u_blank_counter (
        .clk_in       (clk_in),
        .reset        (reset),
        .blank_start  (blank_start),
        .blank_active (blank_active),
        .blank_addr   (blank_addr),
        .blank_last   (blank_last)
    );

    pixel_writer u_pixel_writer (
        .clk_in           (clk_in),
        .reset            (reset),
        .state            (fsm_state),
        .byte_accept      (byte_accept),
        .data_rx          (data_rx),
        .blank_active     (blank_active),
        .blank_addr       (blank_addr),
        .ram_address      (ram_address),
        .ram_data         (ram_data),
        .ram_write_enable (ram_write_enable)
    );

    display_settings u_display_settings (
        .clk_in            (clk_in),
        .reset             (reset),
        .settings_strobe   (settings_strobe),
        .settings_op       (settings_op),
        .settings_arg      (settings_arg),
        .rgb_enable        (rgb_enable),
        .brightness_enable (brightness_enable)
    );

endmodule

/* verilog/matrix_pkg.sv */
// panel geometry, address widths, command byte codes
// and the controller state type

package matrix_pkg;

    // byte lanes
    localparam int DATA_BITS = 8;

    // 64 x 32 panel, two bytes per pixel
    localparam int ROW_BITS = 5;
    localparam int COL_BITS = 6;
    localparam int PIX_SEL_BITS = 1;
    localparam int ADDR_BITS = ROW_BITS + COL_BITS + PIX_SEL_BITS;
    localparam int RAM_DEPTH = 4096;

    // display enables
    localparam int BRIGHTNESS_LEVELS = 6;
    localparam int RGB_CHANNELS = 3;

    // command bytes, ascii letters and digits
    typedef enum logic [DATA_BITS-1:0] {
        OP_RED_ON      = 8'h52,
        OP_RED_OFF     = 8'h72,
        OP_GREEN_ON    = 8'h47,
        OP_GREEN_OFF   = 8'h67,
        OP_BLUE_ON     = 8'h42,
        OP_BLUE_OFF    = 8'h62,
        OP_BRIGHT_OFF  = 8'h30,
        OP_BRIGHT_1    = 8'h31,
        OP_BRIGHT_2    = 8'h32,
        OP_BRIGHT_3    = 8'h33,
        OP_BRIGHT_4    = 8'h34,
        OP_BRIGHT_5    = 8'h35,
        OP_BRIGHT_6    = 8'h36,
        OP_BRIGHT_ALL  = 8'h39,
        // next byte carries the brightness mask
        OP_BRIGHT_LOAD = 8'h54,
        OP_BLANK       = 8'h5a,
        // followed by row, column, colour high, colour low
        OP_PIXEL       = 8'h50
    } cmd_opcode_t;

    // controller states
    typedef enum logic [2:0] {
        IDLE,
        BRIGHT_ARG,
        BLANK,
        PIX_ROW,
        PIX_COL,
        PIX_HI,
        PIX_LO
    } cmd_state_t;

endpackage

/* verilog/pixel_writer.sv */
// ram write port: pixel colour bytes and blank zero fill
// address is row, column, then the inverted byte select

`timescale 1ns/1ps

module pixel_writer (
    input  logic                             clk_in,
    input  logic                             reset,
    input  matrix_pkg::cmd_state_t           state,
    input  logic                             byte_accept,
    input  logic [matrix_pkg::DATA_BITS-1:0] data_rx,
    input  logic                             blank_active,
    input  logic [matrix_pkg::ADDR_BITS-1:0] blank_addr,
    output logic [matrix_pkg::ADDR_BITS-1:0] ram_address,
    output logic [matrix_pkg::DATA_BITS-1:0] ram_data,
    output logic                             ram_write_enable
);
    import matrix_pkg::*;

    logic [ROW_BITS-1:0] row_q;
    logic [COL_BITS-1:0] col_q;
    logic                hi_write;
    logic                lo_write;

    assign hi_write = byte_accept && (state == PIX_HI);
    assign lo_write = byte_accept && (state == PIX_LO);

    // pixel coordinates, upper bits of each byte ignored
    always_ff @(posedge clk_in) begin
        if (byte_accept && state == PIX_ROW) begin
            row_q <= data_rx[ROW_BITS-1:0];
        end
        if (byte_accept && state == PIX_COL) begin
            col_q <= data_rx[COL_BITS-1:0];
        end
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            ram_write_enable <= 1'b0;
        end else begin
            ram_write_enable <= blank_active || hi_write || lo_write;
        end
    end

    always_ff @(posedge clk_in) begin
        if (blank_active) begin
            ram_address <= blank_addr;
            ram_data <= '0;
        end else if (hi_write) begin
            // high colour byte goes to select 1 (little endian)
            ram_address <= {row_q, col_q, PIX_SEL_BITS'(1)};
            ram_data <= data_rx;
        end else if (lo_write) begin
            ram_address <= {row_q, col_q, PIX_SEL_BITS'(0)};
            ram_data <= data_rx;
        end
    end

endmodule
